// File: bus_switch.f
hw/dsp_bus_pkg.sv
hw/move_decode_pkg.sv
hw/bus_request_if.sv
hw/move_decode.sv
hw/move_execute.sv
hw/bus_merge.sv
hw/bus_switch.sv
verification/bus_switch_properties.sv
verification/bus_switch_tb.sv

// File: hw/bus_merge.sv
module bus_merge
	import dsp_bus_pkg::*;
(
	bus_request_if.sink dec_req,	// From decode
	bus_request_if.sink exe_req,	// From execute
	output data_word_t gdb_out,
	output data_word_t xdb_out,
	output data_word_t ydb_out,
	output logic       gdb_write,
	output logic       xdb_write,
	output logic       ydb_write
);

	// Execute is the older instruction and wins the bus
	function automatic data_word_t pick(input logic exe_write, input data_word_t exe_data,
		input logic dec_write, input data_word_t dec_data);
		if (exe_write)
			return exe_data;
		else if (dec_write)
			return dec_data;
		return bus_idle_data;	// Quiet bus
	endfunction

	//////////////////////
	// Per-bus selection
	//////////////////////

	assign gdb_out   = pick(exe_req.gdb_write, exe_req.gdb_data, dec_req.gdb_write, dec_req.gdb_data);
	assign gdb_write = exe_req.gdb_write | dec_req.gdb_write;

	assign xdb_out   = pick(exe_req.xdb_write, exe_req.xdb_data, dec_req.xdb_write, dec_req.xdb_data);
	assign xdb_write = exe_req.xdb_write | dec_req.xdb_write;

	assign ydb_out   = pick(exe_req.ydb_write, exe_req.ydb_data, dec_req.ydb_write, dec_req.ydb_data);
	assign ydb_write = exe_req.ydb_write | dec_req.ydb_write;

endmodule

// File: hw/bus_request_if.sv
interface bus_request_if
	import dsp_bus_pkg::*;
;

	// Write requests of one pipeline stage, valid only for the cycle raised
	data_word_t gdb_data;	// Toward the global bus
	logic       gdb_write;
	data_word_t xdb_data;	// Toward the X bus
	logic       xdb_write;
	data_word_t ydb_data;	// Toward the Y bus
	logic       ydb_write;

	// Pipeline stage side
	modport source (output gdb_data, gdb_write, xdb_data, xdb_write, ydb_data, ydb_write);

	// Merge side
	modport sink (input gdb_data, gdb_write, xdb_data, xdb_write, ydb_data, ydb_write);

endinterface

// File: hw/bus_switch.sv
module bus_switch
	import dsp_bus_pkg::*;
(
	input  logic       Clk,
	input  logic       reset,
	input  data_word_t pdb,	// Program data bus
	input  logic       rep_hold,	// Repeat from the program control unit
	input  data_word_t gdb_in,	// What other units put on the buses
	input  data_word_t xdb_in,
	input  data_word_t ydb_in,
	output data_word_t gdb_out,
	output logic       gdb_write,
	output data_word_t xdb_out,
	output logic       xdb_write,
	output data_word_t ydb_out,
	output logic       ydb_write
);

	data_word_t dec_word;	// Decode to execute

	bus_request_if dec_req ();	// Decode stage requests
	bus_request_if exe_req ();	// Execute stage requests

	//////////////////////
	// Pipeline stages
	//////////////////////

	move_decode u_decode (
		.Clk      (Clk),
		.reset    (reset),
		.pdb      (pdb),
		.rep_hold (rep_hold),
		.dec_word (dec_word),
		.req      (dec_req)
	);

	move_execute u_execute (
		.Clk      (Clk),
		.reset    (reset),
		.dec_word (dec_word),
		.gdb_in   (gdb_in),
		.xdb_in   (xdb_in),
		.ydb_in   (ydb_in),
		.req      (exe_req)
	);

	// Drive the three buses
	bus_merge u_merge (
		.dec_req   (dec_req),
		.exe_req   (exe_req),
		.gdb_out   (gdb_out),
		.xdb_out   (xdb_out),
		.ydb_out   (ydb_out),
		.gdb_write (gdb_write),
		.xdb_write (xdb_write),
		.ydb_write (ydb_write)
	);

endmodule

// File: hw/dsp_bus_pkg.sv
package dsp_bus_pkg;

	//////////////////////
	// Data word
	//////////////////////

	localparam int data_width = 24;	// One DSP word

	typedef logic [data_width-1:0] data_word_t;	// Bus data and instruction words

	// All-zero instruction
	// Its move field is zero so neither stage acts on it
	localparam data_word_t nop_word = '0;

	//////////////////////
	// Bus requests
	//////////////////////

	localparam logic bus_write    = 1'b1;	// Stage drives the bus this cycle
	localparam logic bus_no_write = 1'b0;	// Stage leaves the bus alone

	// Value shown on a data output while nobody writes it
	localparam data_word_t bus_idle_data = '0;

endpackage

// File: hw/move_decode.sv
module move_decode
	import dsp_bus_pkg::*, move_decode_pkg::*;
(
	input  logic       Clk,
	input  logic       reset,
	input  data_word_t pdb,	// Fetched program word
	input  logic       rep_hold,	// REP in effect
	output data_word_t dec_word,	// Instruction held in decode
	bus_request_if.source req
);

	logic      xy_move;	// X:/Y: Class I in decode
	logic      two_word;	// Next program word is an operand
	logic      imm_load;	// Immediate into a register
	reg_side_t dst_side;

	//////////////////////
	// Stage register
	//////////////////////

	always_ff @(posedge Clk)
	begin
		if (reset)
			dec_word <= nop_word;
		else if (rep_hold)
			dec_word <= dec_word;	// Keep the repeated instruction
		else if (two_word)
			dec_word <= nop_word;	// Operand word must not run as an instruction
		else
			dec_word <= pdb;
	end

	//////////////////////
	// Immediate placement
	//////////////////////

	always_comb
	begin
		xy_move  = is_xy_class1(dec_word);
		two_word = xy_move &&
			((ea_field(dec_word) == ea_immediate) || (ea_field(dec_word) == ea_absolute));
		imm_load = xy_move && dec_word[dir_bit] && (ea_field(dec_word) == ea_immediate);
		dst_side = reg_side(xy_reg_code(dec_word));

		// Nothing on the buses by default
		req.gdb_data  = bus_idle_data;
		req.gdb_write = bus_no_write;
		req.xdb_data  = bus_idle_data;
		req.xdb_write = bus_no_write;
		req.ydb_data  = bus_idle_data;
		req.ydb_write = bus_no_write;

		if (imm_load)
		begin
			if (dec_word[agu_dst_bit])	// AGU destination takes it from gdb
			begin
				req.gdb_data  = pdb;
				req.gdb_write = bus_write;
			end
			else
			begin
				case (dst_side)
					SIDE_X:
					begin
						req.xdb_data  = pdb;	// x0, x1, a0, a1, a2, a
						req.xdb_write = bus_write;
					end
					SIDE_Y:
					begin
						req.ydb_data  = pdb;	// y0, y1, b0, b1, b2, b
						req.ydb_write = bus_write;
					end
					default: ;	// Unknown code, no bus
				endcase
			end
		end
	end

endmodule

// File: hw/move_decode_pkg.sv
package move_decode_pkg;
	import dsp_bus_pkg::*;

	//////////////////////
	// Field positions
	//////////////////////

	localparam int move_msb    = 23;	// Parallel move field
	localparam int move_lsb    = 8;
	localparam int ea_msb      = 13;	// Effective address mode
	localparam int ea_lsb      = 8;
	localparam int dir_bit     = 15;	// 1 means memory into register
	localparam int space_bit   = 19;	// 1 means Y space
	localparam int agu_dst_bit = 21;	// Register is in the AGU
	localparam int class1_bit  = 14;	// Class I of X:/Y: moves

	// Opcode patterns, aligned to the top of the move field
	localparam logic [5:0] r_class_pattern  = 6'b001000;	// R: register to register
	localparam logic [1:0] xy_class_pattern = 2'b01;	// X: or Y: memory move

	// Addressing modes taking a second program word
	localparam logic [5:0] ea_immediate = 6'b110100;	// #xxxxxx
	localparam logic [5:0] ea_absolute  = 6'b110000;	// Absolute address

	//////////////////////
	// Register codes
	//////////////////////

	typedef logic [4:0] reg_code_t;

	localparam reg_code_t reg_x0 = 5'b00100;
	localparam reg_code_t reg_x1 = 5'b00101;
	localparam reg_code_t reg_y0 = 5'b00110;
	localparam reg_code_t reg_y1 = 5'b00111;
	localparam reg_code_t reg_a0 = 5'b01000;
	localparam reg_code_t reg_b0 = 5'b01001;
	localparam reg_code_t reg_a2 = 5'b01010;
	localparam reg_code_t reg_b2 = 5'b01011;
	localparam reg_code_t reg_a1 = 5'b01100;
	localparam reg_code_t reg_b1 = 5'b01101;
	localparam reg_code_t reg_a  = 5'b01110;
	localparam reg_code_t reg_b  = 5'b01111;

	// Which bus a register talks through
	typedef enum logic [1:0] {SIDE_X, SIDE_Y, SIDE_AGU} reg_side_t;

	function automatic reg_side_t reg_side(input reg_code_t code);
		case (code)
			reg_x0, reg_x1, reg_a0, reg_a1, reg_a2, reg_a: return SIDE_X;
			reg_y0, reg_y1, reg_b0, reg_b1, reg_b2, reg_b: return SIDE_Y;
			default: return SIDE_AGU;	// Address and control registers
		endcase
	endfunction

	//////////////////////
	// Field helpers
	//////////////////////

	function automatic logic has_move(input data_word_t w);
		return w[move_msb:move_lsb] != '0;
	endfunction

	function automatic logic is_r_move(input data_word_t w);
		return w[move_msb -: 6] == r_class_pattern;
	endfunction

	function automatic logic is_xy_class1(input data_word_t w);
		return (w[move_msb -: 2] == xy_class_pattern) && w[class1_bit];
	endfunction

	function automatic logic [5:0] ea_field(input data_word_t w);
		return w[ea_msb:ea_lsb];
	endfunction

	function automatic reg_code_t r_src_code(input data_word_t w);
		return w[17:13];
	endfunction

	function automatic reg_code_t r_dst_code(input data_word_t w);
		return w[12:8];
	endfunction

	// Register code is scattered around the space bit
	function automatic reg_code_t xy_reg_code(input data_word_t w);
		return {w[21], w[20], w[18], w[17], w[16]};
	endfunction

endpackage

// File: hw/move_execute.sv
module move_execute
	import dsp_bus_pkg::*, move_decode_pkg::*;
(
	input  logic       Clk,
	input  logic       reset,
	input  data_word_t dec_word,	// Word leaving decode
	input  data_word_t gdb_in,	// Driven by other units
	input  data_word_t xdb_in,
	input  data_word_t ydb_in,
	bus_request_if.source req
);

	data_word_t exe_word;	// Instruction being executed
	reg_side_t  src_side;	// R: source register
	reg_side_t  dst_side;	// R: destination register
	reg_side_t  xy_side;	// X:/Y: register

	//////////////////////
	// Stage register
	//////////////////////

	// Loads every cycle so a held decode word repeats here
	always_ff @(posedge Clk)
	begin
		if (reset)
			exe_word <= nop_word;
		else
			exe_word <= dec_word;
	end

	//////////////////////
	// Bus routing
	//////////////////////

	always_comb
	begin
		src_side = reg_side(r_src_code(exe_word));
		dst_side = reg_side(r_dst_code(exe_word));
		xy_side  = reg_side(xy_reg_code(exe_word));

		req.gdb_data  = bus_idle_data;
		req.gdb_write = bus_no_write;
		req.xdb_data  = bus_idle_data;
		req.xdb_write = bus_no_write;
		req.ydb_data  = bus_idle_data;
		req.ydb_write = bus_no_write;

		if (!has_move(exe_word))
		begin
			// No parallel move
		end
		else if (is_r_move(exe_word))
		begin
			if ((src_side != SIDE_AGU) && (dst_side == SIDE_AGU))
			begin
				// Data ALU register out onto gdb
				req.gdb_data  = (src_side == SIDE_X) ? xdb_in : ydb_in;
				req.gdb_write = bus_write;
			end
			else if ((src_side == SIDE_AGU) && (dst_side == SIDE_X))
			begin
				req.xdb_data  = gdb_in;	// AGU into x0, x1 or a
				req.xdb_write = bus_write;
			end
			else if ((src_side == SIDE_AGU) && (dst_side == SIDE_Y))
			begin
				req.ydb_data  = gdb_in;	// AGU into y0, y1 or b
				req.ydb_write = bus_write;
			end
			// ALU to ALU and AGU to AGU use internal paths
		end
		else if (is_xy_class1(exe_word) && (ea_field(exe_word) != ea_immediate))
		begin
			case ({exe_word[space_bit], exe_word[dir_bit]})
				2'b00:	// Register to X memory
				begin
					req.xdb_data  = (xy_side == SIDE_Y) ? ydb_in : gdb_in;
					req.xdb_write = (xy_side != SIDE_X);
				end
				2'b01:	// X memory to register
				begin
					req.ydb_data  = xdb_in;
					req.ydb_write = (xy_side == SIDE_Y);
					req.gdb_data  = xdb_in;
					req.gdb_write = (xy_side == SIDE_AGU);
				end
				2'b10:	// Register to Y memory
				begin
					req.ydb_data  = (xy_side == SIDE_X) ? xdb_in : gdb_in;
					req.ydb_write = (xy_side != SIDE_Y);
				end
				default:	// Y memory to register
				begin
					req.xdb_data  = ydb_in;
					req.xdb_write = (xy_side == SIDE_X);
					req.gdb_data  = ydb_in;
					req.gdb_write = (xy_side == SIDE_AGU);
				end
			endcase
		end
		// Immediate operands were already placed by decode
	end

endmodule

// File: run_sim.sh
#!/bin/sh
rm -f build.log sim.log
verilator --binary --assert --top-module bus_switch_tb -f bus_switch.f \
	-Mdir obj_dir -o bus_switch_sim > build.log 2>&1 &&
	./obj_dir/bus_switch_sim > sim.log 2>&1
grep -q "All checks passed" sim.log && echo "PASS" ||
	{ echo "FAIL, see build.log and sim.log"; exit 1; }

// File: verification/bus_switch_properties.sv
module bus_switch_properties
	import dsp_bus_pkg::*;
(
	input logic       Clk,
	input logic       reset,
	input logic       rep_hold,
	input data_word_t dec_word,	// Decode stage register
	input logic [2:0] out_write,	// Top level flags in y x g order
	input logic [2:0] dec_write,	// Decode requests in y x g order
	input logic [2:0] exe_write	// Execute requests in y x g order
);

	int unsigned fail_count = 0;

	//////////////////////
	// Pipeline rules
	//////////////////////

	// Both stages hold a NOP once a reset edge has passed
	quiet_after_reset: assert property (@(posedge Clk) reset |=> (out_write == 3'b000))
		else
		begin
			fail_count++;
			$error("Bus write in the cycle after reset");
		end

	write_is_or: assert property (@(posedge Clk) disable iff (reset)
		out_write == (dec_write | exe_write))
		else
		begin
			fail_count++;
			$error("Write output differs from the OR of the stage flags");
		end

	// REP freezes decode
	hold_keeps_word: assert property (@(posedge Clk) disable iff (reset)
		rep_hold |=> $stable(dec_word))
		else
		begin
			fail_count++;
			$error("Decode word changed during repeat hold");
		end

endmodule

bind bus_switch bus_switch_properties props (
	.Clk       (Clk),
	.reset     (reset),
	.rep_hold  (rep_hold),
	.dec_word  (dec_word),
	.out_write ({ydb_write, xdb_write, gdb_write}),
	.dec_write ({dec_req.ydb_write, dec_req.xdb_write, dec_req.gdb_write}),
	.exe_write ({exe_req.ydb_write, exe_req.xdb_write, exe_req.gdb_write})
);

// File: verification/bus_switch_tb.sv
module bus_switch_tb
	import dsp_bus_pkg::*, move_decode_pkg::*;
;

	localparam int cycle_limit = 600;	// About 315 stimulus cycles plus margin

	// Bus index in the expected vectors
	localparam logic [1:0] gdb_i  = 2'd0;
	localparam logic [1:0] xdb_i  = 2'd1;
	localparam logic [1:0] ydb_i  = 2'd2;
	localparam logic [1:0] no_bus = 2'd3;

	typedef struct packed {
		logic [2:0]       w;	// Write flags in y x g order
		data_word_t [2:0] v;	// Data in y x g order
	} bus_state_t;

	logic       Clk = 1'b0;
	logic       reset;
	logic       rep_hold;
	data_word_t pdb;
	data_word_t gdb_in;
	data_word_t xdb_in;
	data_word_t ydb_in;
	data_word_t gdb_out;
	data_word_t xdb_out;
	data_word_t ydb_out;
	logic       gdb_write;
	logic       xdb_write;
	logic       ydb_write;

	data_word_t model_dec;	// Decode register of the model
	data_word_t model_exe;	// Execute register of the model
	bus_state_t want;
	string      test_name = "reset";
	int         errors = 0;
	int         checks = 0;
	int         cycles = 0;

	bus_switch dut (.*);

	always #4 Clk = ~Clk;

	////////////////////
	// Reference model
	////////////////////

	function automatic reg_side_t side_of(input reg_code_t c);
		if (c inside {reg_x0, reg_x1, reg_a0, reg_a1, reg_a2, reg_a})
			return SIDE_X;
		if (c inside {reg_y0, reg_y1, reg_b0, reg_b1, reg_b2, reg_b})
			return SIDE_Y;
		return SIDE_AGU;	// Everything else sits behind gdb
	endfunction

	function automatic logic [1:0] bus_of(input reg_side_t s);
		return (s == SIDE_X) ? xdb_i : (s == SIDE_Y) ? ydb_i : gdb_i;
	endfunction

	function automatic bus_state_t request(input logic [1:0] bus, input data_word_t val);
		bus_state_t r;
		r = '0;
		if (bus != no_bus)
		begin
			r.w[bus] = 1'b1;
			r.v[bus] = val;
		end
		return r;
	endfunction

	function automatic bus_state_t expected_outputs(input data_word_t d, input data_word_t e,
		input data_word_t p, input data_word_t g, input data_word_t x, input data_word_t y);
		data_word_t [3:0] ins;
		logic [1:0]       dbus;
		logic [1:0]       ebus;
		logic [1:0]       src;
		logic [1:0]       dst;
		logic [1:0]       mem;
		data_word_t       eval;
		bus_state_t       dq;
		bus_state_t       eq;
		bus_state_t       r;
		ins  = {data_word_t'(0), y, x, g};
		dbus = no_bus;
		ebus = no_bus;
		eval = '0;
		// Decode places the immediate operand
		if ((d[23:22] == 2'b01) && d[14] && d[15] && (d[13:8] == ea_immediate))
		begin
			src = bus_of(side_of({d[21], d[20], d[18], d[17], d[16]}));
			if (d[21])
				dbus = gdb_i;
			else if (src != gdb_i)
				dbus = src;
		end
		if (e[23:18] == 6'b001000)	// R: move
		begin
			src = bus_of(side_of(e[17:13]));
			dst = bus_of(side_of(e[12:8]));
			if ((src != gdb_i) && (dst == gdb_i))
			begin
				ebus = gdb_i;
				eval = ins[src];
			end
			else if ((src == gdb_i) && (dst != gdb_i))
			begin
				ebus = dst;
				eval = g;
			end
		end
		else if ((e[23:22] == 2'b01) && e[14] && (e[13:8] != ea_immediate))
		begin
			src = bus_of(side_of({e[21], e[20], e[18], e[17], e[16]}));
			mem = e[19] ? ydb_i : xdb_i;	// Memory space bus
			if (src != mem)
			begin
				ebus = e[15] ? src : mem;	// Read goes to the register's bus
				eval = e[15] ? ins[mem] : ins[src];
			end
		end
		dq = request(dbus, p);
		eq = request(ebus, eval);
		r.w = dq.w | eq.w;	// Execute wins each bus
		r.v[0] = eq.w[0] ? eq.v[0] : dq.v[0];
		r.v[1] = eq.w[1] ? eq.v[1] : dq.v[1];
		r.v[2] = eq.w[2] ? eq.v[2] : dq.v[2];
		return r;
	endfunction

	// Model pipeline with hold and nullification
	always @(posedge Clk)
	begin
		if (reset)
		begin
			model_dec <= nop_word;
			model_exe <= nop_word;
		end
		else
		begin
			model_exe <= model_dec;
			if (!rep_hold)
				model_dec <= ((model_dec[23:22] == 2'b01) && model_dec[14] &&
					(model_dec[13:8] inside {ea_immediate, ea_absolute})) ? nop_word : pdb;
		end
	end

	// Outputs settle by the falling edge
	always @(negedge Clk)
	begin
		want = expected_outputs(model_dec, model_exe, pdb, gdb_in, xdb_in, ydb_in);
		checks++;
		if ({ydb_write, xdb_write, gdb_write} !== want.w)
		begin
			errors++;
			$display("Mismatch in %s: writes (y x g) expected %b actual %b", test_name,
				want.w, {ydb_write, xdb_write, gdb_write});
		end
		if ({ydb_out, xdb_out, gdb_out} !== want.v)
		begin
			errors++;
			$display("Mismatch in %s: data (y x g) expected %h actual %h", test_name,
				want.v, {ydb_out, xdb_out, gdb_out});
		end
	end

	always @(posedge Clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout: stimulus still running after %0d cycles", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	////////////////////
	// Stimulus
	////////////////////

	task automatic drive(input data_word_t word, input logic hold);
		@(posedge Clk);
		pdb      <= word;
		rep_hold <= hold;
		gdb_in   <= data_word_t'($urandom);	// Fresh bus values each cycle
		xdb_in   <= data_word_t'($urandom);
		ydb_in   <= data_word_t'($urandom);
	endtask

	function automatic data_word_t r_word(input reg_code_t src, input reg_code_t dst);
		return {6'b001000, src, dst, 8'($urandom)};
	endfunction

	function automatic data_word_t xy_word(input logic space, input logic dir,
		input reg_code_t code, input logic [5:0] ea);
		return {2'b01, code[4], code[3], space, code[2], code[1], code[0], dir, 1'b1, ea,
			8'($urandom)};
	endfunction

	function automatic reg_code_t pick_code(input reg_side_t side);
		reg_code_t  xs [6];
		reg_code_t  ys [6];
		logic [2:0] k;
		xs = '{reg_x0, reg_x1, reg_a0, reg_a1, reg_a2, reg_a};
		ys = '{reg_y0, reg_y1, reg_b0, reg_b1, reg_b2, reg_b};
		k  = 3'($urandom_range(5, 0));
		if (side == SIDE_X)
			return xs[k];
		if (side == SIDE_Y)
			return ys[k];
		return ($urandom_range(1, 0) == 1) ? {1'b1, 4'($urandom)} : {3'b000, 2'($urandom)};
	endfunction

	function automatic reg_side_t random_alu_side();
		return ($urandom_range(1, 0) == 1) ? SIDE_X : SIDE_Y;
	endfunction

	initial
	begin
		logic [5:0] ea;
		void'($urandom(19872));
		reset    <= 1'b1;
		rep_hold <= 1'b0;
		pdb      <= nop_word;	// Decode loads this on the first edge after reset
		gdb_in   <= '0;
		xdb_in   <= '0;
		ydb_in   <= '0;
		repeat (4) @(posedge Clk);
		reset <= 1'b0;

		test_name = "immediate";
		repeat (24)
		begin
			drive(xy_word(1'($urandom), 1'b1, pick_code(reg_side_t'(2'($urandom_range(2, 0)))),
				ea_immediate), 1'b0);
			drive(r_word(pick_code(SIDE_AGU), pick_code(SIDE_X)), 1'b0);	// Operand word
			drive(nop_word, 1'b0);
		end

		test_name = "r_move";
		repeat (8)
			for (int s = 0; s < 4; s++)
				drive(r_word(pick_code(s[1] ? SIDE_AGU : random_alu_side()),
					pick_code(s[0] ? SIDE_AGU : random_alu_side())), 1'b0);

		test_name = "xy_class1";
		repeat (6)
			for (int c = 0; c < 4; c++)
				for (int s = 0; s < 3; s++)
				begin
					ea = ($urandom_range(1, 0) == 1) ? ea_absolute : {1'b0, 5'($urandom)};
					drive(xy_word(c[1], c[0], pick_code(reg_side_t'(2'(s))), ea), 1'b0);
					drive(r_word(pick_code(SIDE_AGU), pick_code(random_alu_side())), 1'b0);
				end

		test_name = "repeat";
		for (int i = 0; i < 4; i++)
		begin
			if (i[0])
				drive(xy_word(1'($urandom), 1'($urandom), pick_code(SIDE_AGU), 6'b011001), 1'b0);
			else
				drive(r_word(pick_code(random_alu_side()), pick_code(SIDE_AGU)), 1'b0);
			repeat (5)
				drive(data_word_t'($urandom), 1'b1);
			drive(nop_word, 1'b0);
		end

		test_name = "priority";
		repeat (8)
		begin
			drive(r_word(pick_code(SIDE_AGU), pick_code(SIDE_X)), 1'b0);
			drive(xy_word(1'($urandom), 1'b1, pick_code(SIDE_X), ea_immediate), 1'b0);
			drive(data_word_t'($urandom), 1'b0);
			drive(nop_word, 1'b0);
		end

		drive(nop_word, 1'b0);
		repeat (2) @(posedge Clk);
		$display("Checks run: %0d, mismatches: %0d, assertion failures: %0d", checks, errors,
			dut.props.fail_count);
		if ((errors == 0) && (dut.props.fail_count == 0))
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
